// File: src/pmb_consts.svh
// process monitor link constants

`ifndef PMB_CONSTS_SVH
`define PMB_CONSTS_SVH

// --------------------
// counters
// --------------------

// counter width, the MSB doubles as overflow flag
`define PMB_COUNT_WIDTH 16

// speed N, speed P, leakage
`define PMB_NUM_SENSORS 3

// --------------------
// host link
// --------------------

// divider and powerdown chain length
`define PMB_CTRL_WORD_BITS 8

// request synchroniser stages
`define PMB_REQ_SYNC_DEPTH 3

`endif

// File: src/pmb_pkg.sv
// process monitor link types

`default_nettype none

`include "pmb_consts.svh"

package pmb_pkg;

  // one counter word
  typedef logic [`PMB_COUNT_WIDTH-1:0] count_t;

  // bit 0 N, bit 1 P, bit 2 leakage
  typedef logic [`PMB_NUM_SENSORS-1:0] sensor_vec_t;

  // host command as {shift_en, select_ctr}
  typedef enum logic [1:0] {
    cmd_deselect    = 2'b00,
    cmd_select      = 2'b01,
    cmd_shift_ctrl  = 2'b10,
    cmd_shift_count = 2'b11
  } pmb_cmd_e;

  typedef enum logic [1:0] {
    st_idle     = 2'b00,
    st_counting = 2'b01,
    st_save     = 2'b11,
    st_stop     = 2'b10
  } link_state_e;

  // powerdown bit 3 is a spare
  typedef struct packed {
    logic [1:0] div_leak;
    logic [1:0] div_speed;
    logic [3:0] powerdown;
  } ctrl_fields_t;

  // shifted in as raw, read out as fields
  typedef union packed {
    logic [`PMB_CTRL_WORD_BITS-1:0] raw;
    ctrl_fields_t                   fields;
  } pmb_ctrl_word_u;

endpackage

`default_nettype wire

// File: src/sensor_count_if.sv
// counter control and result bundle

`timescale 1ns/1ps
`default_nettype none

interface sensor_count_if ();
  import pmb_pkg::*;

  // per channel enable from the link FSM
  sensor_vec_t count_en;
  // one-cycle counter clear
  logic        clear;
  // any registered enable still high
  logic        busy;
  count_t      counts [$bits(sensor_vec_t)];

  modport ctrl (
    output count_en,
    output clear,
    input  busy
  );

  modport bank (
    input  count_en,
    input  clear,
    output busy,
    output counts
  );

  modport snap (
    input counts
  );

endinterface

`default_nettype wire

// File: src/pmb_link_ctrl.sv
// host link controller
// request sync, command decode, config chain and measurement FSM

`timescale 1ns/1ps
`default_nettype none

`include "pmb_consts.svh"

module pmb_link_ctrl (
  input  logic                 rc_osc_i_after_mux,
  input  logic                 pmbw_rstn,
  input  logic                 req_i,
  input  logic                 shift_en_i,
  input  logic                 select_ctr_i,
  input  logic                 serial_i,
  output logic                 ack_o,
  output pmb_pkg::sensor_vec_t powerdown_o,
  output logic [1:0]           div_speed_o,
  output logic [1:0]           div_leak_o,
  output logic                 capture_o,
  output logic                 shift_o,
  output pmb_pkg::sensor_vec_t active_mask_o,
  sensor_count_if.ctrl         cnt
);
  import pmb_pkg::*;

  logic [`PMB_REQ_SYNC_DEPTH-1:0] req_sync_q;
  logic                           req_sync;

  logic shift_en_q;
  logic select_ctr_q;
  logic serial_q;

  pmb_cmd_e    cmd;
  logic        cmd_valid;
  link_state_e state_q;

  pmb_ctrl_word_u ctrl_word_q;
  sensor_vec_t    active_mask;
  sensor_vec_t    powerdown_q;
  logic [1:0]     div_speed_q;
  logic [1:0]     div_leak_q;

  logic ack_q;
  logic clear_q;
  logic capture_q;
  logic shift_q;

  // --------------------
  // request synchroniser
  // --------------------

  always_ff @(posedge rc_osc_i_after_mux or negedge pmbw_rstn) begin
    if (!pmbw_rstn) begin
      req_sync_q <= '0;
    end else begin
      req_sync_q <= {req_sync_q[`PMB_REQ_SYNC_DEPTH-2:0], req_i};
    end
  end

  assign req_sync = req_sync_q[`PMB_REQ_SYNC_DEPTH-1];

  // host holds these stable before raising req, one stage is enough
  always_ff @(posedge rc_osc_i_after_mux or negedge pmbw_rstn) begin
    if (!pmbw_rstn) begin
      shift_en_q   <= 1'b0;
      select_ctr_q <= 1'b0;
      serial_q     <= 1'b0;
    end else begin
      shift_en_q   <= shift_en_i;
      select_ctr_q <= select_ctr_i;
      serial_q     <= serial_i;
    end
  end

  // --------------------
  // command decode
  // --------------------

  assign cmd       = pmb_cmd_e'({shift_en_q, select_ctr_q});
  // new command only while the previous ack is down
  assign cmd_valid = req_sync && !ack_q;

  // channels that are powered up
  assign active_mask = ~ctrl_word_q.fields.powerdown[$bits(sensor_vec_t)-1:0];

  // --------------------
  // measurement FSM
  // --------------------

  always_ff @(posedge rc_osc_i_after_mux or negedge pmbw_rstn) begin
    if (!pmbw_rstn) begin
      state_q            <= st_idle;
      ack_q              <= 1'b0;
      clear_q            <= 1'b0;
      capture_q          <= 1'b0;
      shift_q            <= 1'b0;
      ctrl_word_q.fields <= '{div_leak: 2'b00, div_speed: 2'b00, powerdown: 4'hf};
      powerdown_q        <= '1;
      div_speed_q        <= 2'b00;
      div_leak_q         <= 2'b00;
    end else begin
      // single-cycle strobes
      clear_q   <= 1'b0;
      capture_q <= 1'b0;
      shift_q   <= 1'b0;

      // ack follows the request back down in every state
      if (!req_sync) begin
        ack_q <= 1'b0;
      end

      case (state_q)
        st_idle: begin
          if (cmd_valid) begin
            ack_q <= 1'b1;
            case (cmd)
              cmd_shift_ctrl: begin
                // new bit enters at bit 0, oldest ends at div_leak[1]
                ctrl_word_q.raw <= {ctrl_word_q.raw[`PMB_CTRL_WORD_BITS-2:0], serial_q};
              end
              cmd_select: begin
                div_speed_q <= ctrl_word_q.fields.div_speed;
                div_leak_q  <= ctrl_word_q.fields.div_leak;
                powerdown_q <= ctrl_word_q.fields.powerdown[$bits(sensor_vec_t)-1:0];
                clear_q     <= 1'b1;
                state_q     <= st_counting;
              end
              cmd_shift_count: begin
                shift_q <= 1'b1;
              end
              cmd_deselect: begin
                powerdown_q <= '1;
              end
            endcase
          end
        end

        st_counting: begin
          // anything but deselect stays pending without ack
          if (cmd_valid && cmd == cmd_deselect) begin
            state_q <= st_save;
          end
        end

        st_save: begin
          // enables are dropped here, wait for the bank to settle
          if (!cnt.busy) begin
            capture_q <= 1'b1;
            state_q   <= st_stop;
          end
        end

        st_stop: begin
          powerdown_q <= '1;
          ack_q       <= 1'b1;
          state_q     <= st_idle;
        end

        default: begin
          state_q <= st_idle;
        end
      endcase
    end
  end

  // --------------------
  // outputs
  // --------------------

  assign cnt.count_en = (state_q == st_counting) ? active_mask : '0;
  assign cnt.clear    = clear_q;

  assign ack_o         = ack_q;
  assign powerdown_o   = powerdown_q;
  assign div_speed_o   = div_speed_q;
  assign div_leak_o    = div_leak_q;
  assign capture_o     = capture_q;
  assign shift_o       = shift_q;
  assign active_mask_o = active_mask;

endmodule

`default_nettype wire

// File: src/sensor_counter_bank.sv
// saturating sensor pulse counters

`timescale 1ns/1ps
`default_nettype none

`include "pmb_consts.svh"

module sensor_counter_bank (
  input  logic                 rc_osc_i_after_mux,
  input  logic                 pmbw_rstn,
  input  pmb_pkg::sensor_vec_t sensor_pulse_i,
  sensor_count_if.bank         cnt
);
  import pmb_pkg::*;

  sensor_vec_t en_q;

  // enable sees one register, count starts and stops a cycle late
  always_ff @(posedge rc_osc_i_after_mux or negedge pmbw_rstn) begin
    if (!pmbw_rstn) begin
      en_q <= '0;
    end else begin
      en_q <= cnt.count_en;
    end
  end

  assign cnt.busy = |en_q;

  // --------------------
  // per channel counters
  // --------------------

  for (genvar g = 0; g < `PMB_NUM_SENSORS; g++) begin : g_counter
    count_t count_q;

    always_ff @(posedge rc_osc_i_after_mux or negedge pmbw_rstn) begin
      if (!pmbw_rstn) begin
        count_q <= '0;
      end else if (cnt.clear) begin
        count_q <= '0;
      end else if (en_q[g] && sensor_pulse_i[g]) begin
        if (&count_q[`PMB_COUNT_WIDTH-2:0]) begin
          // saturated, flag overflow and hold
          count_q[`PMB_COUNT_WIDTH-1] <= 1'b1;
        end else begin
          count_q[`PMB_COUNT_WIDTH-2:0] <= count_q[`PMB_COUNT_WIDTH-2:0] + 1'b1;
        end
      end
    end

    assign cnt.counts[g] = count_q;
  end

endmodule

`default_nettype wire

// File: src/count_snapshot_shifter.sv
// count snapshots and serial readout

`timescale 1ns/1ps
`default_nettype none

module count_snapshot_shifter (
  input  logic                 rc_osc_i_after_mux,
  input  logic                 pmbw_rstn,
  input  logic                 capture_i,
  input  logic                 shift_i,
  input  pmb_pkg::sensor_vec_t active_mask_i,
  sensor_count_if.snap         cnt,
  output logic                 serial_o
);
  import pmb_pkg::*;

  localparam int CW = $bits(count_t);
  localparam int NS = $bits(sensor_vec_t);

  sensor_vec_t sel_oh;
  sensor_vec_t snap_msb;
  logic        serial_q;

  // lowest active channel as one-hot
  assign sel_oh = active_mask_i & (~active_mask_i + 1'b1);

  // --------------------
  // snapshot registers
  // --------------------

  for (genvar g = 0; g < NS; g++) begin : g_snap
    count_t snap_q;

    always_ff @(posedge rc_osc_i_after_mux or negedge pmbw_rstn) begin
      if (!pmbw_rstn) begin
        snap_q <= '0;
      end else if (capture_i && active_mask_i[g]) begin
        snap_q <= cnt.counts[g];
      end else if (shift_i && sel_oh[g]) begin
        // rotate so the word comes back after a full read
        snap_q <= {snap_q[CW-2:0], snap_q[CW-1]};
      end
    end

    assign snap_msb[g] = snap_q[CW-1];
  end

  // serial bit, zero when nothing is selected
  always_ff @(posedge rc_osc_i_after_mux or negedge pmbw_rstn) begin
    if (!pmbw_rstn) begin
      serial_q <= 1'b0;
    end else if (shift_i) begin
      serial_q <= |(snap_msb & sel_oh);
    end
  end

  assign serial_o = serial_q;

endmodule

`default_nettype wire

// File: src/pmb_sensor_wrapper.sv
// process monitor link top level

`timescale 1ns/1ps
`default_nettype none

module pmb_sensor_wrapper (
  input  logic                 rc_osc_i_after_mux,
  input  logic                 pmbw_rstn,

  // host link
  input  logic                 req_i,
  input  logic                 shift_en_i,
  input  logic                 select_ctr_i,
  input  logic                 serial_i,
  output logic                 ack_o,
  output logic                 serial_o,

  // sensor side
  input  pmb_pkg::sensor_vec_t sensor_pulse_i,
  output pmb_pkg::sensor_vec_t powerdown_o,
  output logic [1:0]           div_speed_o,
  output logic [1:0]           div_leak_o
);
  import pmb_pkg::*;

  logic        capture;
  logic        shift;
  sensor_vec_t active_mask;

  sensor_count_if cnt_if ();

  // --------------------
  // link controller
  // --------------------

  pmb_link_ctrl i_pmb_link_ctrl (
    .rc_osc_i_after_mux (rc_osc_i_after_mux),
    .pmbw_rstn          (pmbw_rstn),
    .req_i              (req_i),
    .shift_en_i         (shift_en_i),
    .select_ctr_i       (select_ctr_i),
    .serial_i           (serial_i),
    .ack_o              (ack_o),
    .powerdown_o        (powerdown_o),
    .div_speed_o        (div_speed_o),
    .div_leak_o         (div_leak_o),
    .capture_o          (capture),
    .shift_o            (shift),
    .active_mask_o      (active_mask),
    .cnt                (cnt_if.ctrl)
  );

  // --------------------
  // counters
  // --------------------

  sensor_counter_bank i_sensor_counter_bank (
    .rc_osc_i_after_mux (rc_osc_i_after_mux),
    .pmbw_rstn          (pmbw_rstn),
    .sensor_pulse_i     (sensor_pulse_i),
    .cnt                (cnt_if.bank)
  );

  // --------------------
  // readout
  // --------------------

  count_snapshot_shifter i_count_snapshot_shifter (
    .rc_osc_i_after_mux (rc_osc_i_after_mux),
    .pmbw_rstn          (pmbw_rstn),
    .capture_i          (capture),
    .shift_i            (shift),
    .active_mask_i      (active_mask),
    .cnt                (cnt_if.snap),
    .serial_o           (serial_o)
  );

endmodule

`default_nettype wire

// File: test/pmb_tb_tasks.svh
// testbench helpers for the process monitor link

`ifndef PMB_TB_TASKS_SVH
`define PMB_TB_TASKS_SVH

localparam int ACK_TIMEOUT = 200;
localparam int REQ_DRAIN   = 6;

// --------------------
// models
// --------------------

function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

// lower bits count up to all ones, the next pulse sets the MSB and it holds
function automatic count_t expected_count(input int pulses);
  if (pulses >= 2 ** ($bits(count_t) - 1)) begin
    return '1;
  end
  return count_t'(pulses);
endfunction

// --------------------
// failure reporting
// --------------------

task automatic stop_on_mismatch(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
  $display("[FAIL] %0t: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
  $display("ERRORS FOUND");
  $fatal(1, "stopping at first mismatch");
endtask

task automatic stop_on_timeout(input string what);
  $display("timeout at %0t: %s", $time, what);
  $display("ERRORS FOUND");
  $fatal(1, "handshake timeout");
endtask

task automatic check_vec(input string what, input sensor_vec_t got, input sensor_vec_t exp);
  if (got !== exp) begin
    stop_on_mismatch(what, 32'(got), 32'(exp));
  end
endtask

task automatic check_div(input string what, input logic [1:0] got, input logic [1:0] exp);
  if (got !== exp) begin
    stop_on_mismatch(what, 32'(got), 32'(exp));
  end
endtask

task automatic check_count(input string what, input count_t got, input count_t exp);
  if (got !== exp) begin
    stop_on_mismatch(what, 32'(got), 32'(exp));
  end
endtask

task automatic check_bit(input string what, input logic got, input logic exp);
  if (got !== exp) begin
    stop_on_mismatch(what, 32'(got), 32'(exp));
  end
endtask

// --------------------
// host link
// --------------------

// four-phase exchange, called and left on a falling edge
task automatic send_cmd(input pmb_cmd_e cmd, input logic bit_val);
  int waited;
  shift_en   = cmd[1];
  select_ctr = cmd[0];
  serial_in  = bit_val;
  req        = 1'b1;
  waited     = 0;
  while (ack !== 1'b1) begin
    @(negedge rc_osc_i_after_mux);
    waited++;
    if (waited > ACK_TIMEOUT) begin
      stop_on_timeout($sformatf("ack_o never rose for %s", cmd.name()));
    end
  end
  req    = 1'b0;
  waited = 0;
  while (ack !== 1'b0) begin
    @(negedge rc_osc_i_after_mux);
    waited++;
    if (waited > ACK_TIMEOUT) begin
      stop_on_timeout($sformatf("ack_o never fell after %s", cmd.name()));
    end
  end
endtask

// request held for a while, ack must stay low the whole time
task automatic expect_no_ack(input pmb_cmd_e cmd, input int cycles);
  shift_en   = cmd[1];
  select_ctr = cmd[0];
  serial_in  = 1'b0;
  req        = 1'b1;
  repeat (cycles) begin
    @(negedge rc_osc_i_after_mux);
    check_bit($sformatf("ack_o for blocked %s", cmd.name()), ack, 1'b0);
  end
  req = 1'b0;
  // let the request synchroniser empty
  repeat (REQ_DRAIN) @(negedge rc_osc_i_after_mux);
endtask

// oldest bit ends up in div_leak[1]
task automatic load_config(input pmb_ctrl_word_u word);
  for (int i = $bits(word) - 1; i >= 0; i--) begin
    send_cmd(cmd_shift_ctrl, word.raw[i]);
  end
endtask

// MSB first, one bit per request
task automatic read_count(output count_t word);
  for (int i = $bits(count_t) - 1; i >= 0; i--) begin
    send_cmd(cmd_shift_count, 1'b0);
    word[i] = serial_out;
  end
endtask

task automatic drive_random_pulses(input int cycles);
  sensor_vec_t p;
  repeat (cycles) begin
    rng_state    = xorshift32(rng_state);
    p            = rng_state[2:0];
    sensor_pulse = p;
    for (int g = 0; g < $bits(sensor_vec_t); g++) begin
      if (p[g]) begin
        pulse_cnt[g]++;
      end
    end
    @(negedge rc_osc_i_after_mux);
  end
  sensor_pulse = '0;
endtask

`endif

// File: test/tb_pmb_sensor_wrapper.sv
// directed testbench for the process monitor link

`timescale 1ns/1ps
`default_nettype none

module tb_pmb_sensor_wrapper;
  import pmb_pkg::*;

  localparam int OVF_PULSES = 32770;

  logic        rc_osc_i_after_mux;
  logic        pmbw_rstn;
  logic        req;
  logic        shift_en;
  logic        select_ctr;
  logic        serial_in;
  logic        ack;
  logic        serial_out;
  sensor_vec_t sensor_pulse;
  sensor_vec_t powerdown;
  logic [1:0]  div_speed;
  logic [1:0]  div_leak;

  logic [31:0] rng_state;
  int          pulse_cnt [3];

  `include "pmb_tb_tasks.svh"

  always #5 rc_osc_i_after_mux = ~rc_osc_i_after_mux;

  pmb_sensor_wrapper i_pmb_sensor_wrapper (
    .rc_osc_i_after_mux (rc_osc_i_after_mux),
    .pmbw_rstn          (pmbw_rstn),
    .req_i              (req),
    .shift_en_i         (shift_en),
    .select_ctr_i       (select_ctr),
    .serial_i           (serial_in),
    .ack_o              (ack),
    .serial_o           (serial_out),
    .sensor_pulse_i     (sensor_pulse),
    .powerdown_o        (powerdown),
    .div_speed_o        (div_speed),
    .div_leak_o         (div_leak)
  );

  // --------------------
  // measurement steps
  // --------------------

  task automatic start_measurement(input ctrl_fields_t cfg);
    pmb_ctrl_word_u word;
    word.fields = cfg;
    load_config(word);
    send_cmd(cmd_select, 1'b0);
    foreach (pulse_cnt[g]) pulse_cnt[g] = 0;
    repeat (4) @(negedge rc_osc_i_after_mux);
  endtask

  task automatic finish_measurement();
    repeat (4) @(negedge rc_osc_i_after_mux);
    send_cmd(cmd_deselect, 1'b0);
    check_vec("powerdown_o after stop", powerdown, '1);
  endtask

  // --------------------
  // directed tests
  // --------------------

  task automatic test_reset();
    count_t word;
    check_bit("ack_o after reset", ack, 1'b0);
    check_bit("serial_o after reset", serial_out, 1'b0);
    check_vec("powerdown_o after reset", powerdown, '1);
    check_div("div_speed_o after reset", div_speed, 2'b00);
    check_div("div_leak_o after reset", div_leak, 2'b00);
    // nothing powered up, readout is all zeros
    read_count(word);
    check_count("readout after reset", word, '0);
    send_cmd(cmd_deselect, 1'b0);
    check_vec("powerdown_o after idle deselect", powerdown, '1);
  endtask

  task automatic test_config();
    ctrl_fields_t cfg;
    cfg = '{div_leak: 2'b10, div_speed: 2'b01, powerdown: 4'b1010};
    start_measurement(cfg);
    check_div("div_speed_o after select", div_speed, cfg.div_speed);
    check_div("div_leak_o after select", div_leak, cfg.div_leak);
    check_vec("powerdown_o while counting", powerdown, cfg.powerdown[2:0]);
    finish_measurement();
  endtask

  // N and leakage up, P down
  task automatic test_measurement();
    ctrl_fields_t cfg;
    count_t       word;
    cfg = '{div_leak: 2'b01, div_speed: 2'b11, powerdown: 4'b0010};
    start_measurement(cfg);
    drive_random_pulses(200);
    finish_measurement();
    read_count(word);
    check_count("N count readout", word, expected_count(pulse_cnt[0]));
  endtask

  task automatic test_rotation();
    ctrl_fields_t cfg;
    count_t       word;
    read_count(word);
    check_count("N count after full rotation", word, expected_count(pulse_cnt[0]));
    cfg = '{div_leak: 2'b00, div_speed: 2'b10, powerdown: 4'b1101};
    start_measurement(cfg);
    drive_random_pulses(150);
    finish_measurement();
    read_count(word);
    check_count("P count readout", word, expected_count(pulse_cnt[1]));
    cfg = '{div_leak: 2'b11, div_speed: 2'b00, powerdown: 4'b1011};
    start_measurement(cfg);
    drive_random_pulses(120);
    finish_measurement();
    read_count(word);
    check_count("leakage count readout", word, expected_count(pulse_cnt[2]));
  endtask

  task automatic test_overflow();
    ctrl_fields_t cfg;
    count_t       word;
    cfg = '{div_leak: 2'b00, div_speed: 2'b00, powerdown: 4'b1110};
    start_measurement(cfg);
    sensor_pulse = 3'b001;
    repeat (OVF_PULSES) @(negedge rc_osc_i_after_mux);
    sensor_pulse = '0;
    finish_measurement();
    read_count(word);
    check_bit("overflow flag", word[$bits(count_t)-1], 1'b1);
    check_count("saturated N count", word, expected_count(OVF_PULSES));
  endtask

  // shift_ctrl stays pending while counting
  task automatic test_blocked_cmd();
    ctrl_fields_t cfg;
    count_t       word;
    cfg = '{div_leak: 2'b01, div_speed: 2'b01, powerdown: 4'b1110};
    start_measurement(cfg);
    drive_random_pulses(40);
    expect_no_ack(cmd_shift_ctrl, 50);
    finish_measurement();
    read_count(word);
    check_count("N count after blocked command", word, expected_count(pulse_cnt[0]));
  endtask

  initial begin
    rc_osc_i_after_mux = 1'b0;
    pmbw_rstn          = 1'b0;
    req                = 1'b0;
    shift_en           = 1'b0;
    select_ctr         = 1'b0;
    serial_in          = 1'b0;
    sensor_pulse       = '0;
    rng_state          = 32'd85;
    foreach (pulse_cnt[g]) pulse_cnt[g] = 0;
    repeat (8) @(negedge rc_osc_i_after_mux);
    pmbw_rstn = 1'b1;
    @(negedge rc_osc_i_after_mux);

    test_reset();
    test_config();
    test_measurement();
    test_rotation();
    test_overflow();
    test_blocked_cmd();

    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+src
+incdir+test
src/pmb_pkg.sv
src/sensor_count_if.sv
src/pmb_link_ctrl.sv
src/sensor_counter_bank.sv
src/count_snapshot_shifter.sv
src/pmb_sensor_wrapper.sv
test/tb_pmb_sensor_wrapper.sv
